//--- hdl/replay_pkg.sv
// Replay engine shared definitions

package replay_pkg;

   // Stream beat widths
   localparam int DATA_W  = 64;
   localparam int USER_W  = 16;
   localparam int KEEP_W  = DATA_W / 8;

   // Width of the replay pass count
   localparam int COUNT_W = 32;

   // Default packet memory address width, 64 beats
   localparam int MEM_DEPTH_BITS_DEF  = 6;

   // Default egress FIFO depth bits, 8 entries
   localparam int FIFO_DEPTH_BITS_DEF = 3;

   // One stream beat, last on top and data at the bottom
   typedef struct packed {
      logic              last;
      logic [USER_W-1:0] user;
      logic [KEEP_W-1:0] keep;
      logic [DATA_W-1:0] data;
   } beat_t;

   // Packet memory word holds one whole beat
   typedef beat_t mem_word_t;

endpackage

//--- hdl/mem_port_if.sv
// Packet memory request port

`timescale 1ns/10ps

interface mem_port_if
   import replay_pkg::*;
#(
   parameter int ADDR_W = MEM_DEPTH_BITS_DEF
);

   // Write request
   logic              wr_en;
   logic [ADDR_W-1:0] wr_addr;
   beat_t             wr_beat;

   // Read request and the beat returned one cycle later
   logic              rd_en;
   logic [ADDR_W-1:0] rd_addr;
   logic              rd_valid;
   beat_t             rd_beat;

   modport ctrl (
      output wr_en, wr_addr, wr_beat, rd_en, rd_addr,
      input  rd_valid, rd_beat
   );

   modport mem (
      input  wr_en, wr_addr, wr_beat, rd_en, rd_addr,
      output rd_valid, rd_beat
   );

endinterface

//--- hdl/pkt_mem.sv
// On-chip packet memory

`timescale 1ns/10ps

module pkt_mem
   import replay_pkg::*;
#(
   parameter int MEM_DEPTH_BITS = MEM_DEPTH_BITS_DEF
)
(
   input  logic          axis_aclk_i,
   mem_port_if.mem       mem
);

   localparam int MEM_DEPTH = 2 ** MEM_DEPTH_BITS;

   // Beats stored in arrival order
   mem_word_t mem_q [MEM_DEPTH];

   // Write port
   always_ff @(posedge axis_aclk_i) begin
      if (mem.wr_en) begin
         mem_q[mem.wr_addr] <= mem.wr_beat;
      end
   end

   // Registered read holds its data until the next read
   always_ff @(posedge axis_aclk_i) begin
      if (mem.rd_en) begin
         mem.rd_beat <= mem_q[mem.rd_addr];
      end
   end

   // Valid follows the read request one cycle later
   always_ff @(posedge axis_aclk_i) begin
      mem.rd_valid <= mem.rd_en;
   end

endmodule

//--- hdl/beat_fifo.sv
// Fall-through egress FIFO

`timescale 1ns/10ps

module beat_fifo
   import replay_pkg::*;
#(
   parameter int DEPTH_BITS = FIFO_DEPTH_BITS_DEF
)
(
   input  logic  axis_aclk_i,
   input  logic  rst_n_i,
   input  logic  sw_rst_i,

   input  logic  push_i,
   input  beat_t push_beat_i,

   input  logic  pop_i,
   output beat_t head_o,
   output logic  empty_o,
   output logic  nearly_full_o
);

   localparam int DEPTH = 2 ** DEPTH_BITS;
   localparam logic [DEPTH_BITS:0] FULL_LVL   = (DEPTH_BITS + 1)'(DEPTH);
   localparam logic [DEPTH_BITS:0] NEARLY_LVL = (DEPTH_BITS + 1)'(DEPTH - 1);

   beat_t                 slots_q [DEPTH];
   logic [DEPTH_BITS-1:0] wr_ptr_q;
   logic [DEPTH_BITS-1:0] rd_ptr_q;
   logic [DEPTH_BITS:0]   count_q;
   logic                  do_push;
   logic                  do_pop;

   assign do_pop  = pop_i & (count_q != '0);
   // A full FIFO still takes a beat when one leaves in the same cycle
   assign do_push = push_i & ((count_q != FULL_LVL) | do_pop);

   always_ff @(posedge axis_aclk_i) begin
      if (do_push) begin
         slots_q[wr_ptr_q] <= push_beat_i;
      end
   end

   always_ff @(posedge axis_aclk_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else if (sw_rst_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (do_pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   // Head is the oldest slot, valid whenever not empty
   assign head_o        = slots_q[rd_ptr_q];
   assign empty_o       = (count_q == '0);
   // One or fewer free slots left
   assign nearly_full_o = (count_q >= NEARLY_LVL);

endmodule

//--- hdl/replay_ctrl.sv
// Store and replay controller

`timescale 1ns/10ps

module replay_ctrl
   import replay_pkg::*;
#(
   parameter int MEM_DEPTH_BITS = MEM_DEPTH_BITS_DEF
)
(
   input  logic               axis_aclk_i,
   input  logic               rst_n_i,
   input  logic               sw_rst_i,

   input  logic               wr_done_i,
   input  logic               start_replay_i,
   input  logic [COUNT_W-1:0] replay_count_i,

   input  beat_t              s_beat_i,
   input  logic               s_valid_i,
   output logic               s_ready_o,

   input  logic               fifo_nearly_full_i,
   input  logic               fifo_empty_i,
   input  logic               m_handshake_i,

   mem_port_if.ctrl           mem,

   output logic               replay_busy_o
);

   // Stored beat count reaching this value means the memory is full
   localparam logic [MEM_DEPTH_BITS:0] MEM_FULL = {1'b1, {MEM_DEPTH_BITS{1'b0}}};

   // Store side
   logic                      store_open_q, store_open_d;
   logic [MEM_DEPTH_BITS:0]   wr_cnt_q, wr_cnt_d;
   logic                      s_ready_q;
   logic                      s_accept;

   // Replay side
   logic                      busy_q, busy_d;
   logic                      reading_q, reading_d;
   logic                      handed_q, handed_d;
   logic [MEM_DEPTH_BITS-1:0] rd_addr_q, rd_addr_d;
   logic [COUNT_W-1:0]        passes_q, passes_d;
   logic [MEM_DEPTH_BITS:0]   last_idx;
   logic                      start_ok;
   logic                      rd_en;
   logic                      drained;

   assign s_accept = s_valid_i & s_ready_q;
   assign last_idx = wr_cnt_q - 1'b1;

   // Start only with a closed, non-empty store and a non-zero count
   assign start_ok = start_replay_i & ~busy_q & ~store_open_q & (wr_cnt_q != '0)
                   & (replay_count_i != '0);

   // Keep one slot free for the read already in flight
   assign rd_en = busy_q & reading_q & ~fifo_nearly_full_i & ~sw_rst_i;

   // All reads issued, nothing in flight and the final beat gone
   assign drained = busy_q & ~reading_q & ~mem.rd_valid & fifo_empty_i & handed_q;

   always_comb begin
      store_open_d = store_open_q;
      wr_cnt_d     = wr_cnt_q;
      busy_d       = busy_q;
      reading_d    = reading_q;
      handed_d     = handed_q;
      rd_addr_d    = rd_addr_q;
      passes_d     = passes_q;

      if (s_accept) begin
         wr_cnt_d = wr_cnt_q + 1'b1;
      end
      if (wr_done_i) begin
         store_open_d = 1'b0;
      end

      if (start_ok) begin
         busy_d    = 1'b1;
         reading_d = 1'b1;
         handed_d  = 1'b0;
         rd_addr_d = '0;
         passes_d  = replay_count_i;
      end

      // Wrap at the last stored beat and count one pass
      if (rd_en) begin
         if (rd_addr_q == last_idx[MEM_DEPTH_BITS-1:0]) begin
            rd_addr_d = '0;
            passes_d  = passes_q - 1'b1;
            if (passes_q == COUNT_W'(1)) begin
               reading_d = 1'b0;
            end
         end else begin
            rd_addr_d = rd_addr_q + 1'b1;
         end
      end

      // Beats leaving after the last read belong to the tail of the replay
      if (m_handshake_i && busy_q && !reading_q) begin
         handed_d = 1'b1;
      end
      if (drained) begin
         busy_d   = 1'b0;
         handed_d = 1'b0;
      end

      if (sw_rst_i) begin
         store_open_d = 1'b1;
         wr_cnt_d     = '0;
         busy_d       = 1'b0;
         reading_d    = 1'b0;
         handed_d     = 1'b0;
         rd_addr_d    = '0;
         passes_d     = '0;
      end
   end

   always_ff @(posedge axis_aclk_i) begin
      if (!rst_n_i) begin
         store_open_q <= 1'b1;
         wr_cnt_q     <= '0;
         s_ready_q    <= 1'b0;
         busy_q       <= 1'b0;
         reading_q    <= 1'b0;
         handed_q     <= 1'b0;
         rd_addr_q    <= '0;
         passes_q     <= '0;
      end else begin
         store_open_q <= store_open_d;
         wr_cnt_q     <= wr_cnt_d;
         // Ready registered from next state so it stays low in reset
         s_ready_q    <= store_open_d & (wr_cnt_d != MEM_FULL) & ~busy_d;
         busy_q       <= busy_d;
         reading_q    <= reading_d;
         handed_q     <= handed_d;
         rd_addr_q    <= rd_addr_d;
         passes_q     <= passes_d;
      end
   end

   assign s_ready_o = s_ready_q;

   // Accepted beats go to memory in the same cycle
   assign mem.wr_en   = s_accept;
   assign mem.wr_addr = wr_cnt_q[MEM_DEPTH_BITS-1:0];
   assign mem.wr_beat = s_beat_i;

   assign mem.rd_en   = rd_en;
   assign mem.rd_addr = rd_addr_q;

   // Drops in the cycle after the final beat is handed over
   assign replay_busy_o = busy_q & ~drained;

endmodule

//--- hdl/replay_top.sv
// Packet store and replay engine

`timescale 1ns/10ps

module replay_top
   import replay_pkg::*;
#(
   parameter int MEM_DEPTH_BITS  = MEM_DEPTH_BITS_DEF,
   parameter int FIFO_DEPTH_BITS = FIFO_DEPTH_BITS_DEF
)
(
   input  logic               axis_aclk_i,
   input  logic               rst_n_i,

   input  logic               sw_rst_i,
   input  logic               wr_done_i,
   input  logic               start_replay_i,
   input  logic [COUNT_W-1:0] replay_count_i,

   input  logic [DATA_W-1:0]  s_axis_tdata_i,
   input  logic [KEEP_W-1:0]  s_axis_tkeep_i,
   input  logic [USER_W-1:0]  s_axis_tuser_i,
   input  logic               s_axis_tlast_i,
   input  logic               s_axis_tvalid_i,
   output logic               s_axis_tready_o,

   output logic [DATA_W-1:0]  m_axis_tdata_o,
   output logic [KEEP_W-1:0]  m_axis_tkeep_o,
   output logic [USER_W-1:0]  m_axis_tuser_o,
   output logic               m_axis_tlast_o,
   output logic               m_axis_tvalid_o,
   input  logic               m_axis_tready_i,

   output logic               replay_busy_o
);

   beat_t s_beat;
   beat_t fifo_head;
   logic  fifo_empty;
   logic  fifo_nearly_full;
   logic  m_handshake;

   mem_port_if #(.ADDR_W(MEM_DEPTH_BITS)) mem_if ();

   // Pack the input stream into one memory word
   assign s_beat.last = s_axis_tlast_i;
   assign s_beat.user = s_axis_tuser_i;
   assign s_beat.keep = s_axis_tkeep_i;
   assign s_beat.data = s_axis_tdata_i;

   assign m_handshake = m_axis_tready_i & ~fifo_empty;

   replay_ctrl #(
      .MEM_DEPTH_BITS     (MEM_DEPTH_BITS)
   ) u_ctrl (
      .axis_aclk_i        (axis_aclk_i),
      .rst_n_i            (rst_n_i),
      .sw_rst_i           (sw_rst_i),
      .wr_done_i          (wr_done_i),
      .start_replay_i     (start_replay_i),
      .replay_count_i     (replay_count_i),
      .s_beat_i           (s_beat),
      .s_valid_i          (s_axis_tvalid_i),
      .s_ready_o          (s_axis_tready_o),
      .fifo_nearly_full_i (fifo_nearly_full),
      .fifo_empty_i       (fifo_empty),
      .m_handshake_i      (m_handshake),
      .mem                (mem_if),
      .replay_busy_o      (replay_busy_o)
   );

   pkt_mem #(
      .MEM_DEPTH_BITS     (MEM_DEPTH_BITS)
   ) u_mem (
      .axis_aclk_i        (axis_aclk_i),
      .mem                (mem_if)
   );

   // Read data feeds the egress FIFO directly
   beat_fifo #(
      .DEPTH_BITS         (FIFO_DEPTH_BITS)
   ) u_fifo (
      .axis_aclk_i        (axis_aclk_i),
      .rst_n_i            (rst_n_i),
      .sw_rst_i           (sw_rst_i),
      .push_i             (mem_if.rd_valid),
      .push_beat_i        (mem_if.rd_beat),
      .pop_i              (m_handshake),
      .head_o             (fifo_head),
      .empty_o            (fifo_empty),
      .nearly_full_o      (fifo_nearly_full)
   );

   // FIFO head drives the output stream
   assign m_axis_tdata_o  = fifo_head.data;
   assign m_axis_tkeep_o  = fifo_head.keep;
   assign m_axis_tuser_o  = fifo_head.user;
   assign m_axis_tlast_o  = fifo_head.last;
   assign m_axis_tvalid_o = ~fifo_empty;

endmodule

//--- tests/tb_replay_assert.sv
// Stream protocol assertions

`timescale 1ns/10ps

module tb_replay_assert
   import replay_pkg::*;
(
   input logic              clk_i,
   input logic              rst_n_i,
   input logic              sw_rst_i,
   input logic              s_ready_i,
   input logic              m_valid_i,
   input logic              m_ready_i,
   input logic [DATA_W-1:0] m_data_i,
   input logic              busy_i
);

   // Number of assertion failures
   int fail_cnt = 0;

   // Output beat holds until the sink takes it
   hold_while_stalled : assert property (
      @(posedge clk_i) disable iff (!rst_n_i || sw_rst_i)
      (m_valid_i && !m_ready_i) |=> (m_valid_i && $stable(m_data_i))
   ) else begin
      $error("m_axis beat changed while m_axis_tready_i was low");
      fail_cnt++;
   end

   // No store while a replay runs
   no_store_when_busy : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      busy_i |-> !s_ready_i
   ) else begin
      $error("s_axis_tready_o high while replay_busy_o is high");
      fail_cnt++;
   end

   quiet_after_reset : assert property (
      @(posedge clk_i) !rst_n_i |=> !m_valid_i
   ) else begin
      $error("m_axis_tvalid_o high after reset");
      fail_cnt++;
   end

endmodule

bind replay_top tb_replay_assert u_assert (
   .clk_i     (axis_aclk_i),
   .rst_n_i   (rst_n_i),
   .sw_rst_i  (sw_rst_i),
   .s_ready_i (s_axis_tready_o),
   .m_valid_i (m_axis_tvalid_o),
   .m_ready_i (m_axis_tready_i),
   .m_data_i  (m_axis_tdata_o),
   .busy_i    (replay_busy_o)
);

//--- tests/tb_replay.sv
// Replay engine testbench

`timescale 1ns/10ps

module tb_replay
   import replay_pkg::*;
();

   localparam int MEM_BEATS   = 2 ** MEM_DEPTH_BITS_DEF;
   localparam int MAX_PASSES  = 3;
   localparam int SLACK       = 8;
   localparam int NUM_REPLAYS = 8;
   // Every round stores up to a full memory and replays it up to MAX_PASSES times
   localparam int WATCHDOG_CYCLES = NUM_REPLAYS * MEM_BEATS * (MAX_PASSES + 1) * SLACK;

   logic               clk;
   logic               rst_n;
   logic               sw_rst;
   logic               wr_done;
   logic               start_replay;
   logic [COUNT_W-1:0] replay_count;
   logic [DATA_W-1:0]  s_tdata;
   logic [KEEP_W-1:0]  s_tkeep;
   logic [USER_W-1:0]  s_tuser;
   logic               s_tlast;
   logic               s_tvalid;
   logic               s_tready;
   logic [DATA_W-1:0]  m_tdata;
   logic [KEEP_W-1:0]  m_tkeep;
   logic [USER_W-1:0]  m_tuser;
   logic               m_tlast;
   logic               m_tvalid;
   logic               m_tready;
   logic               replay_busy;

   int    seed       = 32'h0811541f;
   int    data_errs  = 0;
   int    proto_errs = 0;
   bit    rand_ready = 1'b0;
   beat_t store_q [$];
   beat_t exp_q [$];

   replay_top UUT (
      .axis_aclk_i     (clk),
      .rst_n_i         (rst_n),
      .sw_rst_i        (sw_rst),
      .wr_done_i       (wr_done),
      .start_replay_i  (start_replay),
      .replay_count_i  (replay_count),
      .s_axis_tdata_i  (s_tdata),
      .s_axis_tkeep_i  (s_tkeep),
      .s_axis_tuser_i  (s_tuser),
      .s_axis_tlast_i  (s_tlast),
      .s_axis_tvalid_i (s_tvalid),
      .s_axis_tready_o (s_tready),
      .m_axis_tdata_o  (m_tdata),
      .m_axis_tkeep_o  (m_tkeep),
      .m_axis_tuser_o  (m_tuser),
      .m_axis_tlast_o  (m_tlast),
      .m_axis_tvalid_o (m_tvalid),
      .m_axis_tready_i (m_tready),
      .replay_busy_o   (replay_busy)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
      if (act !== exp) begin
         data_errs++;
         $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
      end
   endtask

   task automatic report_failure(input string what);
      proto_errs++;
      $display("Failure at %0t: %s", $time, what);
   endtask

   task automatic print_counts();
      $display("Errors: %0d value, %0d protocol, %0d assertion",
               data_errs, proto_errs, UUT.u_assert.fail_cnt);
   endtask

   function automatic int rand_range(input int lo, input int hi);
      return lo + int'(($random(seed) & 32'h7fff_ffff) % (hi - lo + 1));
   endfunction

   // Model of the store and check of every beat that leaves m_axis
   task automatic sample_stream();
      beat_t got;
      if (!rst_n || sw_rst) begin
         store_q.delete();
      end else if (s_tvalid && s_tready) begin
         store_q.push_back('{last: s_tlast, user: s_tuser, keep: s_tkeep, data: s_tdata});
      end
      if (rst_n && m_tvalid && m_tready) begin
         if (exp_q.size() == 0) begin
            report_failure("m_axis delivered a beat with none expected");
         end else begin
            got = exp_q.pop_front();
            check_value("m_axis_tdata_o", got.data, m_tdata);
            check_value("m_axis_tkeep_o", 64'(got.keep), 64'(m_tkeep));
            check_value("m_axis_tuser_o", 64'(got.user), 64'(m_tuser));
            check_value("m_axis_tlast_o", 64'(got.last), 64'(m_tlast));
         end
      end
   endtask

   // One clock edge with random sink ready under back-pressure
   task automatic next_cycle();
      @(posedge clk);
      sample_stream();
      if (rand_ready) begin
         m_tready <= (($random(seed) & 3) != 0);
      end else begin
         m_tready <= 1'b1;
      end
   endtask

   task automatic wait_store_ready();
      int waited;
      waited = 0;
      while (!s_tready && waited < 10) begin
         next_cycle();
         waited++;
      end
      if (!s_tready) begin
         report_failure("s_axis_tready_o did not rise");
      end
   endtask

   task automatic store_beats(input int n);
      int accepted;
      bit pending;
      accepted = 0;
      pending  = 1'b0;
      while (accepted < n) begin
         next_cycle();
         if (s_tvalid && s_tready) begin
            accepted++;
            pending = 1'b0;
         end
         if (!pending) begin
            if (accepted < n && ($random(seed) & 3) != 0) begin
               s_tdata  <= {$random(seed), $random(seed)};
               s_tkeep  <= KEEP_W'($random(seed));
               s_tuser  <= USER_W'($random(seed));
               // Packet ends at random and always at the end of the store
               s_tlast  <= (accepted == n - 1) || (($random(seed) & 7) == 0);
               s_tvalid <= 1'b1;
               pending  = 1'b1;
            end else begin
               s_tvalid <= 1'b0;
            end
         end
      end
   endtask

   // A start pulse while the store is still open must be ignored
   task automatic start_while_open();
      next_cycle();
      start_replay <= 1'b1;
      replay_count <= COUNT_W'(1);
      next_cycle();
      start_replay <= 1'b0;
      next_cycle();
      check_value("replay_busy_o", 64'(0), 64'(replay_busy));
      check_value("s_axis_tready_o", 64'(1), 64'(s_tready));
   endtask

   // Beats offered to a full memory must be refused
   task automatic offer_extra(input int k);
      repeat (k) begin
         next_cycle();
         check_value("s_axis_tready_o", 64'(0), 64'(s_tready));
         s_tdata  <= {$random(seed), $random(seed)};
         s_tlast  <= 1'b1;
         s_tvalid <= 1'b1;
      end
      next_cycle();
      check_value("s_axis_tready_o", 64'(0), 64'(s_tready));
      s_tvalid <= 1'b0;
   endtask

   task automatic close_store();
      next_cycle();
      wr_done <= 1'b1;
      next_cycle();
      wr_done <= 1'b0;
      next_cycle();
      check_value("s_axis_tready_o", 64'(0), 64'(s_tready));
   endtask

   task automatic soft_reset();
      next_cycle();
      sw_rst <= 1'b1;
      next_cycle();
      sw_rst <= 1'b0;
      next_cycle();
      wait_store_ready();
   endtask

   task automatic replay_and_check(input int count);
      int waited;
      int limit;
      int p;
      for (p = 0; p < count; p++) begin
         foreach (store_q[i]) begin
            exp_q.push_back(store_q[i]);
         end
      end
      limit = (store_q.size() * count + 1) * SLACK;
      next_cycle();
      start_replay <= 1'b1;
      replay_count <= COUNT_W'(count);
      next_cycle();
      start_replay <= 1'b0;
      // Count was latched at the start
      replay_count <= COUNT_W'($random(seed));
      next_cycle();
      if (count == 0) begin
         repeat (SLACK * 4) begin
            check_value("replay_busy_o", 64'(0), 64'(replay_busy));
            next_cycle();
         end
      end else begin
         check_value("replay_busy_o", 64'(1), 64'(replay_busy));
         waited = 0;
         while (replay_busy && waited < limit) begin
            next_cycle();
            waited++;
         end
         if (replay_busy) begin
            report_failure("replay_busy_o stayed high, replay did not finish");
         end else if (exp_q.size() != 0) begin
            report_failure($sformatf("replay_busy_o fell with %0d beats missing",
                                     exp_q.size()));
         end
      end
      // Nothing more may leave once the replay is over
      repeat (4) begin
         next_cycle();
      end
      check_value("m_axis_tvalid_o", 64'(0), 64'(m_tvalid));
      exp_q.delete();
   endtask

   initial begin
      int n_first;
      rst_n        <= 1'b0;
      sw_rst       <= 1'b0;
      wr_done      <= 1'b0;
      start_replay <= 1'b0;
      replay_count <= '0;
      s_tdata      <= '0;
      s_tkeep      <= '0;
      s_tuser      <= '0;
      s_tlast      <= 1'b0;
      s_tvalid     <= 1'b0;
      m_tready     <= 1'b1;

      next_cycle();
      repeat (2) begin
         next_cycle();
         check_value("m_axis_tvalid_o", 64'(0), 64'(m_tvalid));
         check_value("replay_busy_o", 64'(0), 64'(replay_busy));
         check_value("s_axis_tready_o", 64'(0), 64'(s_tready));
      end
      rst_n <= 1'b1;
      next_cycle();
      wait_store_ready();

      n_first = rand_range(16, MEM_BEATS / 2);
      store_beats(n_first);
      start_while_open();
      close_store();
      replay_and_check(rand_range(1, MAX_PASSES));

      // Same store again under back-pressure and then a zero count
      rand_ready = 1'b1;
      replay_and_check(rand_range(1, MAX_PASSES));
      replay_and_check(0);

      // Shorter store after sw_rst
      soft_reset();
      store_beats(rand_range(1, n_first - 1));
      close_store();
      replay_and_check(rand_range(1, MAX_PASSES));

      // Full memory refuses further beats
      soft_reset();
      store_beats(MEM_BEATS);
      offer_extra(4);
      close_store();
      replay_and_check(2);

      repeat (3) begin
         soft_reset();
         store_beats(rand_range(1, MEM_BEATS));
         close_store();
         replay_and_check(rand_range(1, MAX_PASSES));
      end

      print_counts();
      if (data_errs + proto_errs + UUT.u_assert.fail_cnt == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Watchdog expired after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
      print_counts();
      $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

//--- list.f
hdl/replay_pkg.sv
hdl/mem_port_if.sv
hdl/pkt_mem.sv
hdl/beat_fifo.sv
hdl/replay_ctrl.sv
hdl/replay_top.sv
tests/tb_replay_assert.sv
tests/tb_replay.sv

//--- Makefile
# Verilator build and run of the replay engine testbench

VERILATOR ?= verilator
TOP       ?= tb_replay
FILE_LIST ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  ?= *** TEST FAILED ***
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILE_LIST OBJ_DIR LOG VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP) -f $(FILE_LIST)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then \
		echo "Result: FAIL"; exit 1; \
	elif grep -qF '$(PASS_MSG)' $(LOG); then \
		echo "Result: PASS"; \
	else \
		echo "Result: FAIL, the run ended without a verdict"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
